/* include/dcache_params.svh */
// Size and address layout constants of the 4-way data cache.
// Included by the package, the RTL blocks that size memories and the testbench.
// 20-bit byte address: tag in 19..10, set index in 9..2, byte in 1..0.

`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

`define DC_WAYS      4                          // associativity
`define DC_SETS      256                        // sets per way
`define DC_WORD_W    32                         // one word per line
`define DC_ADDR_W    20                         // used byte address bits
`define DC_INDEX_W   8                          // log2 of DC_SETS
`define DC_TAG_W     10                         // addr bits above the index
`define DC_AGE_W     2                          // lru age per way
`define DC_WAY_W     2                          // log2 of DC_WAYS
`define DC_OFF_W     2                          // byte offset in the word
`define DC_INDEX_LSB `DC_OFF_W                  // index starts above the offset
`define DC_TAG_LSB   (`DC_OFF_W + `DC_INDEX_W)  // tag starts above the index

`endif

/* src/dcache_pkg.sv */
// Types shared by the data cache blocks and its testbench.
// Widths come from the params header; structs carry the
// lookup result and the tag and data write requests.

`include "dcache_params.svh"

package dcache_pkg;

  typedef logic [`DC_ADDR_W-1:0]          addr_t;
  typedef logic [`DC_TAG_W-1:0]           tag_t;
  typedef logic [`DC_INDEX_W-1:0]         index_t;
  typedef logic [`DC_WORD_W-1:0]          word_t;
  typedef logic [`DC_WAY_W-1:0]           way_t;
  typedef logic [`DC_AGE_W-1:0]           age_t;
  typedef logic [`DC_WORD_W/8-1:0]        byte_en_t;    // bit n enables byte lane n
  typedef logic [1:0]                     store_size_t; // 0 byte, 1 half, 2 word, 3 illegal
  typedef logic [`DC_WAYS*`DC_WORD_W-1:0] way_words_t;  // way n at bits n*32 +: 32

  typedef enum logic [1:0] {IDLE, LOOKUP, FETCH} dc_state_t;

  typedef struct packed {
    logic hit;         // some valid way matches the tag
    way_t hit_way;     // lowest matching way
    logic has_free;    // some way invalid
    way_t free_way;    // lowest invalid way
    way_t victim_way;  // lowest way of max age
  } lookup_t;

  typedef struct packed {logic en; way_t way; index_t index; tag_t tag;} tag_upd_t;

  typedef struct packed {logic en; way_t way; index_t index; byte_en_t byte_en; word_t data;} data_wr_t;

endpackage

/* src/dcache_tag_array.sv */
// Tag store of the data cache with per-way valid bits and lru ages.
// A set is read at rd_en into registers; lookup is combinational from them
// and holds until the next read, so it serves both LOOKUP and FETCH.
// An update writes the tag, sets valid and ages the other ways of the set.

`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_tag_array (
  input  logic                 CLK,
  input  logic                 resetn,
  input  logic                 rd_en,
  input  dcache_pkg::index_t   rd_index,
  input  dcache_pkg::tag_t     lookup_tag,
  input  dcache_pkg::tag_upd_t upd,
  output dcache_pkg::lookup_t  lookup
);
  import dcache_pkg::*;

  tag_t              tag_mem [`DC_WAYS][`DC_SETS]; // plain ram, no init
  logic [`DC_SETS-1:0] valid_q [`DC_WAYS];
  age_t              age_q   [`DC_WAYS][`DC_SETS];

  tag_t rd_tag_q   [`DC_WAYS]; // set read at accept
  logic rd_valid_q [`DC_WAYS];
  age_t rd_age_q   [`DC_WAYS];

  age_t upd_old_age; // age of the way being touched
  age_t max_age;

  assign upd_old_age = valid_q[upd.way][upd.index] ? age_q[upd.way][upd.index]
                                                   : '1; // empty way counts as oldest

  // valid and age flops, cleared by reset
  always_ff @(posedge CLK or negedge resetn) begin
    if (!resetn) begin
      for (int w = 0; w < `DC_WAYS; w++) begin
        valid_q[w] <= '0;
        for (int s = 0; s < `DC_SETS; s++) begin
          age_q[w][s] <= '0;
        end
      end
    end else if (upd.en) begin
      for (int w = 0; w < `DC_WAYS; w++) begin
        if (way_t'(w) == upd.way) begin
          valid_q[w][upd.index] <= 1'b1;
          age_q[w][upd.index]   <= '0;      // most recent
        end else if (valid_q[w][upd.index] && (age_q[w][upd.index] < upd_old_age)) begin
          age_q[w][upd.index] <= age_q[w][upd.index] + 1'b1; // younger ones age
        end
      end
    end
  end

  // tag ram write and set read
  always_ff @(posedge CLK) begin
    if (upd.en) begin
      tag_mem[upd.way][upd.index] <= upd.tag;
    end
    if (rd_en) begin
      for (int w = 0; w < `DC_WAYS; w++) begin
        rd_tag_q[w]   <= tag_mem[w][rd_index];
        rd_valid_q[w] <= valid_q[w][rd_index];
        rd_age_q[w]   <= age_q[w][rd_index];
      end
    end
  end

  // hit and free way, lowest index wins
  always_comb begin
    lookup = '0;
    for (int w = `DC_WAYS-1; w >= 0; w--) begin
      if (rd_valid_q[w] && (rd_tag_q[w] == lookup_tag)) begin
        lookup.hit     = 1'b1;
        lookup.hit_way = way_t'(w);
      end
      if (!rd_valid_q[w]) begin
        lookup.has_free = 1'b1;
        lookup.free_way = way_t'(w);
      end
    end
    // victim is the oldest way, first one on a tie
    max_age = rd_age_q[0];
    for (int w = 1; w < `DC_WAYS; w++) begin
      if (rd_age_q[w] > max_age) begin
        max_age           = rd_age_q[w];
        lookup.victim_way = way_t'(w);
      end
    end
  end

endmodule

/* src/dcache_data_array.sv */
// Data store of the data cache, one 32-bit word per line in each way.
// Writes go to a single way with byte lane enables.
// All ways of one set are read together at rd_en; the words stay
// registered on way_words until the next read.

`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_data_array (
  input  logic                   CLK,
  input  logic                   rd_en,
  input  dcache_pkg::index_t     rd_index,
  input  dcache_pkg::data_wr_t   wr,
  output dcache_pkg::way_words_t way_words
);
  import dcache_pkg::*;

  word_t rd_word_q [`DC_WAYS]; // registered read per way

  // one inferred ram per way
  for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
    word_t mem [`DC_SETS];
    logic  way_wr;

    assign way_wr = wr.en && (wr.way == way_t'(w));

    always_ff @(posedge CLK) begin
      if (way_wr) begin
        for (int b = 0; b < `DC_WORD_W/8; b++) begin
          if (wr.byte_en[b]) begin
            mem[wr.index][8*b +: 8] <= wr.data[8*b +: 8]; // lane b only
          end
        end
      end
      if (rd_en) begin
        rd_word_q[w] <= mem[rd_index];
      end
    end
  end

  // pack the ways side by side, way 0 lowest
  always_comb begin
    way_words = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      way_words[w*`DC_WORD_W +: `DC_WORD_W] = rd_word_q[w];
    end
  end

endmodule

/* src/dcache_ctrl.sv */
// Controller of the data cache: accepts one request in IDLE, judges hit or
// miss in LOOKUP and waits in FETCH for the word from the SPI side.
// Drives the array reads, tag and data updates and all CPU-side outputs.
// Store data is expected already placed in its byte lanes.

`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_ctrl (
  input  logic                    CLK,
  input  logic                    resetn,
  input  logic                    read_en,
  input  logic                    write_en,
  input  logic                    fetch,
  input  dcache_pkg::addr_t       mem_addr,
  input  dcache_pkg::word_t       write_data_cpu,
  input  dcache_pkg::word_t       write_data_spi,
  input  dcache_pkg::store_size_t store_size,
  input  dcache_pkg::lookup_t     lookup,
  input  dcache_pkg::way_words_t  way_words,
  output logic                    rd_en,
  output dcache_pkg::index_t      rd_index,
  output dcache_pkg::tag_t        lookup_tag,
  output dcache_pkg::tag_upd_t    upd,
  output dcache_pkg::data_wr_t    wr,
  output logic                    cache_miss,
  output logic                    rdata_valid,
  output logic                    write_ready,
  output dcache_pkg::word_t       rdata_out
);
  import dcache_pkg::*;

  dc_state_t   state_q, state_d;
  logic        is_read_q;   // captured request kind
  addr_t       addr_q;      // captured request payload
  store_size_t size_q;
  word_t       wdata_q;
  logic        accept;
  byte_en_t    store_be;
  word_t       hit_word;
  way_t        fill_way;

  assign accept     = (state_q == IDLE) && (read_en || write_en);
  assign rd_en      = accept;                                  // both arrays read at accept
  assign rd_index   = mem_addr[`DC_INDEX_LSB +: `DC_INDEX_W];
  assign lookup_tag = addr_q[`DC_TAG_LSB +: `DC_TAG_W];
  assign hit_word   = way_words[lookup.hit_way*`DC_WORD_W +: `DC_WORD_W];
  assign fill_way   = lookup.has_free ? lookup.free_way : lookup.victim_way;

  always_ff @(posedge CLK or negedge resetn) begin
    if (!resetn) begin
      state_q   <= IDLE;
      is_read_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        is_read_q <= read_en;                                  // read wins over store
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      addr_q  <= mem_addr;
      size_q  <= store_size;
      wdata_q <= write_data_cpu;
    end
  end

  // store lanes, empty when misaligned or size 3
  always_comb begin
    store_be = '0;
    case (size_q)
      2'd0: store_be = byte_en_t'(4'b0001 << addr_q[1:0]);
      2'd1: if (!addr_q[0]) store_be = addr_q[1] ? 4'b1100 : 4'b0011;
      2'd2: if (addr_q[1:0] == 2'b00) store_be = 4'b1111;
      default: store_be = '0;
    endcase
  end

  always_comb begin
    state_d     = state_q;
    cache_miss  = 1'b0;
    rdata_valid = 1'b0;
    write_ready = 1'b0;
    rdata_out   = hit_word;
    upd         = '0;
    upd.index   = addr_q[`DC_INDEX_LSB +: `DC_INDEX_W];
    upd.tag     = lookup_tag;
    wr          = '0;
    wr.index    = addr_q[`DC_INDEX_LSB +: `DC_INDEX_W];
    wr.byte_en  = store_be;
    wr.data     = wdata_q;
    case (state_q)
      IDLE: if (accept) state_d = LOOKUP;
      LOOKUP: begin
        state_d = IDLE;
        if (is_read_q && lookup.hit) begin
          rdata_valid = 1'b1;
          upd.en      = 1'b1;                                  // refresh lru only
          upd.way     = lookup.hit_way;
        end else if (!is_read_q && (store_be == '0)) begin
          write_ready = 1'b1;                                  // bad store, nothing written
        end else if (!is_read_q && lookup.hit) begin
          write_ready = 1'b1;
          upd.en      = 1'b1;
          upd.way     = lookup.hit_way;
          wr.en       = 1'b1;
          wr.way      = lookup.hit_way;
        end else if (!is_read_q && (store_be == '1) && lookup.has_free) begin
          write_ready = 1'b1;                                  // allocate without miss
          upd.en      = 1'b1;
          upd.way     = lookup.free_way;
          wr.en       = 1'b1;
          wr.way      = lookup.free_way;
        end else begin
          cache_miss = 1'b1;
          state_d    = FETCH;
        end
      end
      FETCH: begin
        cache_miss = !fetch;                                   // held until the strobe
        rdata_out  = write_data_spi;
        if (fetch) begin
          state_d     = IDLE;
          rdata_valid = is_read_q;
          upd.en      = 1'b1;
          upd.way     = fill_way;
          wr.en       = 1'b1;
          wr.way      = fill_way;
          wr.byte_en  = '1;                                    // whole line from spi
          wr.data     = write_data_spi;
        end
      end
      default: state_d = IDLE;
    endcase
  end

endmodule

/* src/dcache_top.sv */
// Top level of the 4-way 4 KB data cache.
// Connects the controller to the tag and data arrays; the CPU
// and SPI side ports pass straight to the controller.

`timescale 1ns/1ps

module dcache_top (
  input  logic                    CLK,
  input  logic                    resetn,
  input  logic                    read_en,
  input  logic                    write_en,
  input  logic                    fetch,
  input  dcache_pkg::addr_t       mem_addr,
  input  dcache_pkg::word_t       write_data_cpu,
  input  dcache_pkg::word_t       write_data_spi,
  input  dcache_pkg::store_size_t store_size,
  output logic                    cache_miss,
  output logic                    rdata_valid,
  output logic                    write_ready,
  output dcache_pkg::word_t       rdata_out
);
  import dcache_pkg::*;

  logic       rd_en;       // shared read launch
  index_t     rd_index;
  tag_t       lookup_tag;
  lookup_t    lookup;
  way_words_t way_words;
  tag_upd_t   upd;
  data_wr_t   wr;

  dcache_ctrl u_ctrl (
    .CLK            (CLK),
    .resetn         (resetn),
    .read_en        (read_en),
    .write_en       (write_en),
    .fetch          (fetch),
    .mem_addr       (mem_addr),
    .write_data_cpu (write_data_cpu),
    .write_data_spi (write_data_spi),
    .store_size     (store_size),
    .lookup         (lookup),
    .way_words      (way_words),
    .rd_en          (rd_en),
    .rd_index       (rd_index),
    .lookup_tag     (lookup_tag),
    .upd            (upd),
    .wr             (wr),
    .cache_miss     (cache_miss),
    .rdata_valid    (rdata_valid),
    .write_ready    (write_ready),
    .rdata_out      (rdata_out)
  );

  dcache_tag_array u_tag_array (
    .CLK        (CLK),
    .resetn     (resetn),
    .rd_en      (rd_en),
    .rd_index   (rd_index),
    .lookup_tag (lookup_tag),
    .upd        (upd),
    .lookup     (lookup)
  );

  dcache_data_array u_data_array (
    .CLK       (CLK),
    .rd_en     (rd_en),
    .rd_index  (rd_index),
    .wr        (wr),
    .way_words (way_words)
  );

endmodule

/* test/dcache_assert.sv */
// Port protocol checks for the data cache, bound into dcache_top.
// Read data and store completion are exclusive, outputs stay low in reset,
// and a pending miss ends only in a cycle with the fetch strobe.

`timescale 1ns/1ps

module dcache_assert (
  input logic              CLK,
  input logic              resetn,
  input logic              fetch,
  input logic              cache_miss,
  input logic              rdata_valid,
  input logic              write_ready,
  input dcache_pkg::word_t rdata_out
);
  import dcache_pkg::*;

  a_one_done: assert property (@(posedge CLK) !(rdata_valid && write_ready))
    else $error("rdata_valid and write_ready high in the same cycle");

  a_reset_quiet: assert property (@(posedge CLK)
    !resetn |-> !(cache_miss || rdata_valid || write_ready))
    else $error("cache output active while in reset");

  a_miss_end: assert property (@(posedge CLK) disable iff (!resetn)
    $fell(cache_miss) |-> fetch)                      // strobe ends the miss
    else $error("cache_miss dropped without fetch");

  a_data_known: assert property (@(posedge CLK) disable iff (!resetn)
    rdata_valid |-> !$isunknown(rdata_out))
    else $error("rdata_out unknown while rdata_valid is high");

endmodule

bind dcache_top dcache_assert u_dcache_assert (
  .CLK         (CLK),
  .resetn      (resetn),
  .fetch       (fetch),
  .cache_miss  (cache_miss),
  .rdata_valid (rdata_valid),
  .write_ready (write_ready),
  .rdata_out   (rdata_out)
);

/* test/dcache_tb.sv */
// Testbench for the 4-way data cache top level.
// Drives reads and stores, answers misses with a fetch strobe after an LCG
// chosen wait, and checks every LOOKUP and fetch cycle against a reference model.
// Prints one line per test and a closing count line.

`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_tb;
  import dcache_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int N_RAND     = 120;                    // random ops in test 5
  localparam int N_FIXED    = 27;                     // directed ops over all tests
  localparam int N_OPS      = N_FIXED + N_RAND;
  localparam logic [1:0] PH_IDLE  = 2'd0;             // what the DUT should be doing
  localparam logic [1:0] PH_LOOK  = 2'd1;
  localparam logic [1:0] PH_WAIT  = 2'd2;
  localparam logic [1:0] PH_FETCH = 2'd3;

  typedef struct packed {
    logic  is_read;
    logic  rd_hit;                                    // rdata_valid in LOOKUP
    logic  st_done;                                   // write_ready in LOOKUP
    logic  miss;                                      // cache_miss in LOOKUP
    word_t word;                                      // read or fetched word
  } expect_t;

  logic        CLK = 1'b0;
  logic        resetn, read_en, write_en, fetch;
  addr_t       mem_addr;
  word_t       write_data_cpu, write_data_spi;
  store_size_t store_size;
  logic        cache_miss, rdata_valid, write_ready;
  word_t       rdata_out;

  tag_t    m_tag   [`DC_WAYS][`DC_SETS];              // reference model state
  logic    m_valid [`DC_WAYS][`DC_SETS];
  age_t    m_age   [`DC_WAYS][`DC_SETS];
  word_t   m_word  [`DC_WAYS][`DC_SETS];
  expect_t exp_q;                                     // outcome of the op in flight
  logic [1:0] phase;
  word_t   lcg_state;
  int      err_cnt = 0;
  int      chk_cnt = 0;
  int      op_cnt  = 0;

  dcache_top u_dcache_top (.*);

  always #(CLK_PERIOD/2) CLK = ~CLK;

  function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // line becomes most recent, younger valid ways age by one
  function automatic void lru_touch(input int way, input index_t idx, input tag_t tg);
    age_t old_age;
    int   w;
    old_age = m_valid[way][idx] ? m_age[way][idx] : 2'd3; // empty line counts as oldest
    for (w = 0; w < `DC_WAYS; w++) begin
      if (w != way && m_valid[w][idx] && m_age[w][idx] < old_age) begin
        m_age[w][idx] = m_age[w][idx] + 2'd1;
      end
    end
    m_age[way][idx]   = '0;
    m_valid[way][idx] = 1'b1;
    m_tag[way][idx]   = tg;
  endfunction

  // applies one access to the model and returns what the DUT must show
  function automatic expect_t model_access(input logic is_read, input addr_t addr,
                                           input store_size_t size, input word_t wdata,
                                           input word_t spi);
    expect_t  e;
    index_t   idx;
    tag_t     tg;
    byte_en_t be;
    logic     hit, has_free;
    int       off, nbytes, hw, fw, vw, fill, w, b;
    idx    = addr[`DC_INDEX_LSB +: `DC_INDEX_W];
    tg     = addr[`DC_TAG_LSB +: `DC_TAG_W];
    off    = int'(addr[1:0]);
    nbytes = 1 << int'(size);
    be     = '0;
    if (size != 2'd3 && (off % nbytes) == 0) begin  // naturally aligned only
      for (b = 0; b < 4; b++) begin
        if (b >= off && b < off + nbytes) be[b] = 1'b1;
      end
    end
    hit = 1'b0;
    has_free = 1'b0;
    hw = 0;
    fw = 0;
    vw = 0;
    for (w = 0; w < `DC_WAYS; w++) begin
      if (!hit && m_valid[w][idx] && m_tag[w][idx] == tg) begin
        hit = 1'b1;
        hw  = w;
      end
      if (!has_free && !m_valid[w][idx]) begin
        has_free = 1'b1;
        fw       = w;
      end
      if (m_age[w][idx] > m_age[vw][idx]) vw = w;  // oldest, first on a tie
    end
    e = '0;
    e.is_read = is_read;
    if (is_read && hit) begin
      e.rd_hit = 1'b1;
      e.word   = m_word[hw][idx];
      lru_touch(hw, idx, tg);
    end else if (!is_read && be == '0) begin
      e.st_done = 1'b1;                               // bad store does nothing
    end else if (!is_read && hit) begin
      for (b = 0; b < 4; b++) begin
        if (be[b]) m_word[hw][idx][8*b +: 8] = wdata[8*b +: 8];
      end
      e.st_done = 1'b1;
      lru_touch(hw, idx, tg);
    end else if (!is_read && be == 4'hf && has_free) begin
      m_word[fw][idx] = wdata;                        // allocate, no miss
      e.st_done = 1'b1;
      lru_touch(fw, idx, tg);
    end else begin
      fill = has_free ? fw : vw;
      m_word[fill][idx] = spi;                        // store is not replayed
      e.miss = 1'b1;
      e.word = spi;
      lru_touch(fill, idx, tg);
    end
    return e;
  endfunction

  task automatic check(input string what, input word_t got, input word_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // one request, starts and ends 2 ns after a rising edge
  task automatic cache_access(input logic is_read, input addr_t addr,
                              input store_size_t size, input word_t wdata);
    word_t spi;
    int    wait_cyc;
    logic  missed;
    spi      = lcg_next();
    wait_cyc = 1 + int'(lcg_next() >> 16) % 4;
    exp_q    = model_access(is_read, addr, size, wdata, spi);
    read_en        = is_read;
    write_en       = !is_read;
    mem_addr       = addr;
    store_size     = size;
    write_data_cpu = wdata;
    write_data_spi = spi;
    @(posedge CLK);
    #2;
    read_en  = 1'b0;
    write_en = 1'b0;
    phase    = PH_LOOK;
    @(negedge CLK);
    missed = cache_miss;                              // follow the DUT handshake
    @(posedge CLK);
    #2;
    phase = PH_IDLE;
    if (missed) begin
      phase = PH_WAIT;
      repeat (wait_cyc - 1) begin
        @(posedge CLK);
        #2;
      end
      fetch = 1'b1;
      phase = PH_FETCH;
      @(posedge CLK);
      #2;
      fetch = 1'b0;
      phase = PH_IDLE;
    end
    op_cnt++;
  endtask

  task automatic end_test(input int num, input string name, input int errs_at_start);
    $display("test %0d %s: %0d errors", num, name, err_cnt - errs_at_start);
  endtask

  // compare process, outputs are settled at the falling edge
  always @(negedge CLK) begin
    case (phase)
      PH_LOOK: begin
        check("lookup cache_miss", word_t'(cache_miss), word_t'(exp_q.miss));
        check("lookup rdata_valid", word_t'(rdata_valid), word_t'(exp_q.rd_hit));
        check("lookup write_ready", word_t'(write_ready), word_t'(exp_q.st_done));
        if (exp_q.rd_hit) check("read hit data", rdata_out, exp_q.word);
      end
      PH_WAIT: check("waiting cache_miss", word_t'(cache_miss), 32'd1);
      PH_FETCH: begin
        check("fetch cache_miss", word_t'(cache_miss), 32'd0);
        check("fetch rdata_valid", word_t'(rdata_valid), word_t'(exp_q.is_read));
        check("fetch write_ready", word_t'(write_ready), 32'd0);
        if (exp_q.is_read) check("fetch read data", rdata_out, exp_q.word);
      end
      default: begin                                  // idle and reset, all quiet
        check("idle cache_miss", word_t'(cache_miss), 32'd0);
        check("idle rdata_valid", word_t'(rdata_valid), 32'd0);
        check("idle write_ready", word_t'(write_ready), 32'd0);
      end
    endcase
  end

  // watchdog, worst case op is 6 cycles plus reset margin
  initial begin
    #((N_OPS * 6 + 10) * CLK_PERIOD);
    $display("watchdog expired after %0d operations, the DUT stopped responding", op_cnt);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int    errs0;
    int    i;
    word_t r;
    resetn         = 1'b1;
    read_en        = 1'b0;
    write_en       = 1'b0;
    fetch          = 1'b0;
    mem_addr       = '0;
    write_data_cpu = '0;
    write_data_spi = '0;
    store_size     = '0;
    phase          = PH_IDLE;
    exp_q          = '0;
    lcg_state      = 32'h616f;
    for (i = 0; i < `DC_WAYS * `DC_SETS; i++) begin
      m_valid[i / `DC_SETS][i % `DC_SETS] = 1'b0;
      m_age[i / `DC_SETS][i % `DC_SETS]   = '0;
    end
    #2 resetn = 1'b0;
    repeat (3) @(posedge CLK);
    #2 resetn = 1'b1;

    errs0 = err_cnt;                                  // quiet reset, cold cache
    cache_access(1'b1, 20'h00100, 2'd2, '0);
    cache_access(1'b1, 20'hffffc, 2'd2, '0);
    end_test(1, "reset and cold read miss", errs0);

    errs0 = err_cnt;
    cache_access(1'b1, 20'h12344, 2'd2, '0);
    cache_access(1'b1, 20'h12344, 2'd2, '0);
    end_test(2, "read miss fill then hit", errs0);

    errs0 = err_cnt;
    cache_access(1'b0, 20'h12345, 2'd0, lcg_next()); // byte lane 1
    cache_access(1'b0, 20'h12346, 2'd1, lcg_next()); // upper half
    cache_access(1'b1, 20'h12344, 2'd2, '0);
    cache_access(1'b0, 20'h12345, 2'd1, lcg_next()); // misaligned half
    cache_access(1'b0, 20'h12346, 2'd2, lcg_next()); // misaligned word
    cache_access(1'b0, 20'h12344, 2'd3, lcg_next()); // illegal size
    cache_access(1'b1, 20'h12344, 2'd2, '0);
    cache_access(1'b0, 20'h12344, 2'd2, lcg_next());
    cache_access(1'b1, 20'h12344, 2'd2, '0);
    end_test(3, "store merge on hit and ignored stores", errs0);

    errs0 = err_cnt;
    cache_access(1'b0, 20'h20010, 2'd2, lcg_next()); // allocate into free way
    cache_access(1'b1, 20'h20010, 2'd2, '0);
    cache_access(1'b0, 20'h30021, 2'd0, lcg_next()); // partial store misses
    cache_access(1'b1, 20'h30020, 2'd2, '0);
    end_test(4, "stores to absent lines", errs0);

    errs0 = err_cnt;
    for (i = 0; i < 10; i++) begin                    // five tags on set 33h, twice
      cache_access(1'b1, {tag_t'(i % 5 + 1), 8'h33, 2'b00}, 2'd2, '0);
    end
    for (i = 0; i < N_RAND; i++) begin
      r = lcg_next();
      cache_access(r[24], {tag_t'(r[31:29]), index_t'(r[28:27]), r[26:25]},
                   store_size_t'(r[23:22]), lcg_next());
    end
    end_test(5, "eviction and random mix", errs0);

    $display("5 tests, %0d operations, %0d checks, %0d errors", op_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+include
src/dcache_pkg.sv
src/dcache_tag_array.sv
src/dcache_data_array.sv
src/dcache_ctrl.sv
src/dcache_top.sv
test/dcache_assert.sv
test/dcache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the data cache testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module dcache_tb -o dcache_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/dcache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi
echo "simulation passed"
exit 0
